//--- src/uart_dbg_pkg.sv
`default_nettype none

package uart_dbg_pkg;

  ///////////////////////////////////////////////////
  // Data types
  ///////////////////////////////////////////////////

  // One serial data byte
  typedef logic [7:0] byte_t;

  // Address and length fields as sent on the wire
  typedef logic [63:0] dbg_addr_t;
  typedef logic [63:0] dbg_len_t;

  ///////////////////////////////////////////////////
  // Debug protocol byte codes
  ///////////////////////////////////////////////////

  // Commands from the host
  localparam byte_t CmdRead  = 8'h11;
  localparam byte_t CmdWrite = 8'h12;
  localparam byte_t CmdExec  = 8'h13;

  // Replies where RspAck doubles as the host challenge
  localparam byte_t RspAck = 8'h06;
  localparam byte_t RspEot = 8'h04;

  // Address and length fields are 8 little-endian bytes
  localparam int unsigned FieldBytes = 8;

endpackage

`default_nettype wire

//--- src/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx import uart_dbg_pkg::*; #(
  parameter int unsigned ClkPerBit = 16
) (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  rx_i,
  output logic  rx_valid_o,
  output byte_t rx_byte_o
);

  localparam int unsigned CntWidth = $clog2(ClkPerBit);

  typedef enum logic [1:0] {RxIdle, RxStart, RxData, RxStop} rx_state_e;

  rx_state_e           state_q;
  logic [1:0]          sync_q;
  logic [CntWidth-1:0] cnt_q;
  logic [2:0]          bit_q;
  byte_t               shift_q;
  logic                rx_s;
  logic                tick;

  assign rx_s = sync_q[1];
  assign tick = (cnt_q == '0);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q     <= 2'b11;
      state_q    <= RxIdle;
      cnt_q      <= '0;
      bit_q      <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      sync_q     <= {sync_q[0], rx_i};
      rx_valid_o <= 1'b0;
      if (!tick) cnt_q <= cnt_q - 1'b1;
      case (state_q)
        RxIdle: begin
          // Half a bit period lands on the centre of the start bit
          if (!rx_s) begin
            cnt_q   <= CntWidth'(ClkPerBit / 2 - 1);
            state_q <= RxStart;
          end
        end
        RxStart: begin
          if (tick) begin
            // Line back high means a glitch
            if (rx_s) begin
              state_q <= RxIdle;
            end else begin
              cnt_q   <= CntWidth'(ClkPerBit - 1);
              bit_q   <= '0;
              state_q <= RxData;
            end
          end
        end
        RxData: begin
          if (tick) begin
            cnt_q <= CntWidth'(ClkPerBit - 1);
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) state_q <= RxStop;
          end
        end
        RxStop: begin
          // Framing error drops the byte silently
          if (tick) begin
            rx_valid_o <= rx_s;
            state_q    <= RxIdle;
          end
        end
        default: state_q <= RxIdle;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state_q == RxData && tick) shift_q <= {rx_s, shift_q[7:1]};
  end

  assign rx_byte_o = shift_q;

endmodule

`default_nettype wire

//--- src/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx import uart_dbg_pkg::*; #(
  parameter int unsigned ClkPerBit = 16
) (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  tx_start_i,
  input  byte_t tx_byte_i,
  output logic  tx_o,
  output logic  tx_busy_o
);

  localparam int unsigned CntWidth = $clog2(ClkPerBit);

  logic [CntWidth-1:0] cnt_q;
  logic [3:0]          bits_q;
  logic [8:0]          shift_q;
  logic                load;
  logic                advance;

  assign load    = tx_start_i && !tx_busy_o;
  assign advance = tx_busy_o && (cnt_q == '0) && (bits_q != '0);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_o      <= 1'b1;
      tx_busy_o <= 1'b0;
      cnt_q     <= '0;
      bits_q    <= '0;
    end else if (load) begin
      // Start bit goes out right away and 9 bits remain
      tx_o      <= 1'b0;
      tx_busy_o <= 1'b1;
      cnt_q     <= CntWidth'(ClkPerBit - 1);
      bits_q    <= 4'd9;
    end else if (tx_busy_o) begin
      if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end else if (bits_q == '0) begin
        tx_busy_o <= 1'b0;
      end else begin
        tx_o   <= shift_q[0];
        cnt_q  <= CntWidth'(ClkPerBit - 1);
        bits_q <= bits_q - 1'b1;
      end
    end
  end

  // Data bits then stop bit
  always_ff @(posedge clk) begin
    if (load) shift_q <= {1'b1, tx_byte_i};
    else if (advance) shift_q <= {1'b1, shift_q[8:1]};
  end

endmodule

`default_nettype wire

//--- src/dbg_cmd_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module dbg_cmd_fsm import uart_dbg_pkg::*; #(
  parameter int unsigned MemAddrWidth = 8
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    rx_valid_i,
  input  byte_t                   rx_byte_i,
  input  logic                    tx_busy_i,
  output logic                    tx_start_o,
  output byte_t                   tx_byte_o,
  output logic                    mem_we_o,
  output logic                    mem_re_o,
  output logic [MemAddrWidth-1:0] mem_addr_o,
  output byte_t                   mem_wdata_o,
  input  byte_t                   mem_rdata_i,
  output logic                    exec_o,
  output dbg_addr_t               exec_addr_o
);

  localparam int unsigned FieldCntWidth = $clog2(FieldBytes);

  typedef enum logic [2:0] {
    StIdle, StAddr, StLen, StAck, StWrData, StRdFetch, StRdSend, StEot
  } cmd_state_e;

  cmd_state_e               state_q;
  byte_t                    cmd_q;
  logic [FieldCntWidth-1:0] field_cnt_q;
  logic [MemAddrWidth-1:0]  ptr_q;
  logic [MemAddrWidth-1:0]  remain_q;
  dbg_addr_t                addr_q;
  dbg_len_t                 len_q;
  dbg_len_t                 len_next;
  logic                     field_last;
  logic                     can_send;
  logic                     send_now;
  byte_t                    send_byte;

  assign len_next   = {rx_byte_i, len_q[63:8]};
  assign field_last = (field_cnt_q == FieldCntWidth'(FieldBytes - 1));
  // tx_busy only rises the cycle after our own start strobe
  assign can_send   = !tx_busy_i && !tx_start_o;

  ///////////////////////////////////////////////////
  // Reply selection
  ///////////////////////////////////////////////////

  always_comb begin
    send_now  = 1'b0;
    send_byte = RspAck;
    case (state_q)
      StAck:    send_now = can_send;
      StRdSend: begin
        send_now  = can_send;
        send_byte = mem_rdata_i;
      end
      StEot: begin
        send_now  = can_send;
        send_byte = RspEot;
      end
      default: send_now = 1'b0;
    endcase
  end

  ///////////////////////////////////////////////////
  // Protocol state machine
  ///////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= StIdle;
      cmd_q       <= '0;
      field_cnt_q <= '0;
      ptr_q       <= '0;
      remain_q    <= '0;
      tx_start_o  <= 1'b0;
      exec_o      <= 1'b0;
    end else begin
      tx_start_o <= send_now;
      exec_o     <= 1'b0;
      case (state_q)
        StIdle: begin
          // Anything that is not a command or a challenge is dropped
          if (rx_valid_i) begin
            cmd_q       <= rx_byte_i;
            field_cnt_q <= '0;
            if (rx_byte_i inside {CmdRead, CmdWrite, CmdExec}) state_q <= StAddr;
            else if (rx_byte_i == RspAck) state_q <= StAck;
          end
        end
        StAddr: begin
          if (rx_valid_i) begin
            field_cnt_q <= field_last ? '0 : field_cnt_q + 1'b1;
            if (field_last) state_q <= (cmd_q == CmdExec) ? StAck : StLen;
          end
        end
        StLen: begin
          if (rx_valid_i) begin
            field_cnt_q <= field_last ? '0 : field_cnt_q + 1'b1;
            if (field_last) begin
              ptr_q    <= addr_q[MemAddrWidth-1:0];
              remain_q <= len_next[MemAddrWidth-1:0];
              state_q  <= StAck;
            end
          end
        end
        StAck: begin
          if (send_now) begin
            exec_o <= (cmd_q == CmdExec);
            if (cmd_q == CmdRead || cmd_q == CmdWrite) begin
              if (remain_q == '0) state_q <= StEot;
              else state_q <= (cmd_q == CmdRead) ? StRdFetch : StWrData;
            end else begin
              state_q <= StIdle;
            end
          end
        end
        StWrData: begin
          if (rx_valid_i) begin
            ptr_q    <= ptr_q + 1'b1;
            remain_q <= remain_q - 1'b1;
            if (remain_q == MemAddrWidth'(1)) state_q <= StEot;
          end
        end
        StRdFetch: state_q <= StRdSend;
        StRdSend: begin
          if (send_now) begin
            ptr_q    <= ptr_q + 1'b1;
            remain_q <= remain_q - 1'b1;
            state_q  <= (remain_q == MemAddrWidth'(1)) ? StEot : StRdFetch;
          end
        end
        StEot: begin
          if (send_now) state_q <= StIdle;
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  // Fields arrive LSB first and shift in from the top
  always_ff @(posedge clk) begin
    if (send_now) tx_byte_o <= send_byte;
    if (rx_valid_i && state_q == StAddr) addr_q <= {rx_byte_i, addr_q[63:8]};
    if (rx_valid_i && state_q == StLen) len_q <= len_next;
  end

  assign mem_we_o    = (state_q == StWrData) && rx_valid_i;
  assign mem_re_o    = (state_q == StRdFetch);
  assign mem_addr_o  = ptr_q;
  assign mem_wdata_o = rx_byte_i;
  assign exec_addr_o = addr_q;

endmodule

`default_nettype wire

//--- src/dbg_byte_mem.sv
`timescale 1ns/10ps
`default_nettype none

module dbg_byte_mem import uart_dbg_pkg::*; #(
  parameter int unsigned MemAddrWidth = 8
) (
  input  logic                    clk,
  input  logic                    we_i,
  input  logic                    re_i,
  input  logic [MemAddrWidth-1:0] addr_i,
  input  byte_t                   wdata_i,
  output byte_t                   rdata_o
);

  localparam int unsigned Depth = 2 ** MemAddrWidth;

  byte_t mem_q [Depth];

  // Read data holds until the next read
  always_ff @(posedge clk) begin
    if (we_i) mem_q[addr_i] <= wdata_i;
    if (re_i) rdata_o <= mem_q[addr_i];
  end

endmodule

`default_nettype wire

//--- src/uart_dbg_top.sv
`timescale 1ns/10ps
`default_nettype none

module uart_dbg_top import uart_dbg_pkg::*; #(
  parameter int unsigned ClkPerBit    = 16,
  parameter int unsigned MemAddrWidth = 8
) (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      uart_rx_i,
  output logic      uart_tx_o,
  output logic      exec_o,
  output dbg_addr_t exec_addr_o
);

  logic                    rx_valid;
  byte_t                   rx_byte;
  logic                    tx_start;
  byte_t                   tx_byte;
  logic                    tx_busy;
  logic                    mem_we;
  logic                    mem_re;
  logic [MemAddrWidth-1:0] mem_addr;
  byte_t                   mem_wdata;
  byte_t                   mem_rdata;

  ///////////////////////////////////////////////////
  // Serial line
  ///////////////////////////////////////////////////

  uart_rx #(
    .ClkPerBit ( ClkPerBit )
  ) i_uart_rx (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .rx_i       ( uart_rx_i ),
    .rx_valid_o ( rx_valid  ),
    .rx_byte_o  ( rx_byte   )
  );

  uart_tx #(
    .ClkPerBit ( ClkPerBit )
  ) i_uart_tx (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .tx_start_i ( tx_start  ),
    .tx_byte_i  ( tx_byte   ),
    .tx_o       ( uart_tx_o ),
    .tx_busy_o  ( tx_busy   )
  );

  ///////////////////////////////////////////////////
  // Command unit and memory
  ///////////////////////////////////////////////////

  dbg_cmd_fsm #(
    .MemAddrWidth ( MemAddrWidth )
  ) i_dbg_cmd_fsm (
    .clk         ( clk         ),
    .rst_n_i     ( rst_n_i     ),
    .rx_valid_i  ( rx_valid    ),
    .rx_byte_i   ( rx_byte     ),
    .tx_busy_i   ( tx_busy     ),
    .tx_start_o  ( tx_start    ),
    .tx_byte_o   ( tx_byte     ),
    .mem_we_o    ( mem_we      ),
    .mem_re_o    ( mem_re      ),
    .mem_addr_o  ( mem_addr    ),
    .mem_wdata_o ( mem_wdata   ),
    .mem_rdata_i ( mem_rdata   ),
    .exec_o      ( exec_o      ),
    .exec_addr_o ( exec_addr_o )
  );

  dbg_byte_mem #(
    .MemAddrWidth ( MemAddrWidth )
  ) i_dbg_byte_mem (
    .clk     ( clk       ),
    .we_i    ( mem_we    ),
    .re_i    ( mem_re    ),
    .addr_i  ( mem_addr  ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

endmodule

`default_nettype wire

//--- verification/tb_uart_dbg.sv
`timescale 1ns/10ps
`default_nettype none

module tb_uart_dbg import uart_dbg_pkg::*; ();

  localparam int unsigned ClkPerBit    = 8;
  localparam int unsigned MemAddrWidth = 6;
  localparam int unsigned MemSize      = 2 ** MemAddrWidth;
  localparam int unsigned RandomCmds   = 40;
  // Worst-case bytes on both lines with idle waits counted as bytes
  localparam int unsigned TotalBytes   = 2 + 2 + 2 * 35 + RandomCmds * 39 + 10 + 25;
  localparam int unsigned TimeoutCycles = TotalBytes * 10 * ClkPerBit + TotalBytes * 8 + 1000;

  logic      clk;
  logic      rst_n;
  logic      uart_rx;
  logic      uart_tx;
  logic      exec_strobe;
  dbg_addr_t exec_addr;

  byte_t       tx_q [$];
  byte_t       model_mem [int];
  int unsigned errors;
  int unsigned tests_passed;
  int unsigned tests_failed;
  int unsigned test_err_base;
  string       test_name;
  int unsigned exec_cnt;
  dbg_addr_t   exec_addr_seen;
  int unsigned cycle_cnt;
  int unsigned seed_ret;

  always #2 clk = ~clk;

  uart_dbg_top #(
    .ClkPerBit    ( ClkPerBit    ),
    .MemAddrWidth ( MemAddrWidth )
  ) dut_i (
    .clk         ( clk         ),
    .rst_n_i     ( rst_n       ),
    .uart_rx_i   ( uart_rx     ),
    .uart_tx_o   ( uart_tx     ),
    .exec_o      ( exec_strobe ),
    .exec_addr_o ( exec_addr   )
  );

  //////////////////////////////////////////////////
  // Monitors and watchdog
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the DUT did not answer within %0d cycles", TimeoutCycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Launch strobe sampled away from the active edge
  always @(negedge clk) begin
    if (rst_n && exec_strobe) begin
      exec_cnt       = exec_cnt + 1;
      exec_addr_seen = exec_addr;
    end
  end

  // Decode transmit frames at the centre of each bit
  always begin : tx_monitor
    byte_t b;
    int    i;
    @(negedge clk);
    if (rst_n && !uart_tx) begin
      repeat (ClkPerBit / 2) @(negedge clk);
      for (i = 0; i < 8; i++) begin
        repeat (ClkPerBit) @(negedge clk);
        b[i] = uart_tx;
      end
      repeat (ClkPerBit) @(negedge clk);
      if (!uart_tx) begin
        $display("Framing error: stop bit low on the transmit line");
        errors++;
      end else begin
        tx_q.push_back(b);
      end
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("Fail %s (%s): expected %0h, actual %0h", test_name, name, exp, act);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name     = name;
    test_err_base = errors;
  endtask

  task automatic end_test();
    if (errors == test_err_base) begin
      $display("%s: passed", test_name);
      tests_passed++;
    end else begin
      $display("%s: failed with %0d errors", test_name, errors - test_err_base);
      tests_failed++;
    end
  endtask

  // 8N1 frame with LSB first
  task automatic send_byte(input byte_t b);
    int i;
    @(posedge clk);
    uart_rx <= 1'b0;
    repeat (ClkPerBit) @(posedge clk);
    for (i = 0; i < 8; i++) begin
      uart_rx <= b[i];
      repeat (ClkPerBit) @(posedge clk);
    end
    uart_rx <= 1'b1;
    repeat (ClkPerBit) @(posedge clk);
  endtask

  task automatic send_field(input logic [63:0] value);
    int i;
    for (i = 0; i < FieldBytes; i++) send_byte(value[8*i +: 8]);
  endtask

  task automatic expect_frame(input string name, input byte_t exp);
    byte_t b;
    while (tx_q.size() == 0) @(negedge clk);
    b = tx_q.pop_front();
    check(name, exp, b);
  endtask

  task automatic do_write(input string name, input dbg_addr_t addr, input int unsigned len);
    int unsigned i;
    int unsigned base;
    byte_t       d;
    base = int'(addr % MemSize);
    send_byte(CmdWrite);
    send_field(addr);
    send_field(64'(len));
    expect_frame({name, " ack"}, RspAck);
    for (i = 0; i < len; i++) begin
      d = byte_t'($urandom);
      send_byte(d);
      model_mem[(base + i) % MemSize] = d;
    end
    expect_frame({name, " eot"}, RspEot);
  endtask

  task automatic do_read(input string name, input dbg_addr_t addr, input int unsigned len);
    int unsigned i;
    int unsigned base;
    base = int'(addr % MemSize);
    send_byte(CmdRead);
    send_field(addr);
    send_field(64'(len));
    expect_frame({name, " ack"}, RspAck);
    for (i = 0; i < len; i++) begin
      expect_frame($sformatf("%s byte %0d", name, i), model_mem[(base + i) % MemSize]);
    end
    expect_frame({name, " eot"}, RspEot);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : main
    dbg_addr_t   addr;
    int unsigned len;
    int unsigned base;
    int unsigned run;
    int unsigned n;
    int unsigned exec_before;
    clk          = 1'b0;
    rst_n        = 1'b0;
    uart_rx      = 1'b1;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    exec_cnt     = 0;
    cycle_cnt    = 0;
    seed_ret     = $urandom(32'h813cac77);
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (ClkPerBit) @(posedge clk);

    begin_test("ack_challenge");
    send_byte(RspAck);
    expect_frame("ack_challenge reply", RspAck);
    repeat (20 * ClkPerBit) @(negedge clk);
    check("ack_challenge extra frames", 0, tx_q.size());
    check("ack_challenge exec pulses", 0, exec_cnt);
    end_test();

    begin_test("write_read");
    addr = {$urandom, $urandom};
    len  = 1 + $urandom % 16;
    do_write("write_read write", addr, len);
    do_read("write_read read", addr, len);
    end_test();

    // Upper address bits are random so most addresses wrap
    begin_test("random_traffic");
    for (n = 0; n < RandomCmds; n++) begin
      addr = {$urandom, $urandom};
      len  = 1 + $urandom % 20;
      base = int'(addr % MemSize);
      run  = 0;
      while (run < len && model_mem.exists((base + run) % MemSize)) run++;
      if (run > 0 && ($urandom % 2) == 1) do_read("random read", addr, run);
      else do_write("random write", addr, len);
    end
    end_test();

    begin_test("exec");
    addr        = {$urandom, $urandom};
    exec_before = exec_cnt;
    send_byte(CmdExec);
    send_field(addr);
    expect_frame("exec ack", RspAck);
    check("exec pulse count", exec_before + 1, exec_cnt);
    check("exec entry address", addr, exec_addr_seen);
    end_test();

    begin_test("unknown_and_zero_len");
    send_byte(8'h55);
    repeat (30 * ClkPerBit) @(negedge clk);
    check("unknown command frames", 0, tx_q.size());
    send_byte(RspAck);
    expect_frame("challenge after unknown", RspAck);
    do_read("zero length read", {$urandom, $urandom}, 0);
    end_test();

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
src/uart_dbg_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/dbg_cmd_fsm.sv
src/dbg_byte_mem.sv
src/uart_dbg_top.sv
verification/tb_uart_dbg.sv
